// ==== sources.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/control_pipeline.sv
hdl/fetch.sv
hdl/decode.sv
hdl/scalar_execute.sv
hdl/scalar_memory.sv
hdl/vector_execute.sv
hdl/proc.sv
dv/proc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= proc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/proc_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module proc_tb;
    import isa_pkg::*;

    localparam int VW = `VLANES * `VLANE_W;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [31:0]         imem_wdata;
    logic                halted;
    logic                err;
    logic                s_wb_valid;
    logic [4:0]          s_wb_reg;
    logic [`XLEN-1:0]    s_wb_data;
    logic                v_wb_valid;
    logic [4:0]          v_wb_reg;
    logic [VW-1:0]       v_wb_data;

    // program under construction and the slot of each register's last writer
    logic [31:0] prog [$];
    int          s_last [32];
    int          v_last [32];

    // model state and expected commits as {reg, data}
    logic [`XLEN-1:0]      m_s [32];
    logic [VW-1:0]         m_v [32];
    logic [`XLEN-1:0]      m_mem [64];
    logic [5+`XLEN-1:0]    exp_s [$];
    logic [5+VW-1:0]       exp_v [$];

    logic [31:0] rng;
    string       cur_test;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    int          exp_s_cnt;
    int          exp_v_cnt;
    int          s_seen;
    int          v_seen;
    bit          aborted;

    proc i_dut (
        .clk, .rst_n, .start, .imem_we, .imem_addr, .imem_wdata,
        .halted, .err, .s_wb_valid, .s_wb_reg, .s_wb_data,
        .v_wb_valid, .v_wb_reg, .v_wb_data
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int rand_next();
        rng = xorshift(rng);
        return int'(rng & 32'h7fffffff);
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] opc, input int rd, input int rs1,
                                        input int low);
        logic [31:0] w;
        w = {opc, rd[4:0], rs1[4:0], low[14:0]};
        return w;
    endfunction

    function automatic int later(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    task automatic check_value(input string what, input logic [5+VW-1:0] expected,
                               input logic [5+VW-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    // pads with NOPs so every source is far enough from its writer
    task automatic add_inst(input logic [31:0] w);
        logic [6:0] opc;
        int         rd;
        int         rs1;
        int         rs2;
        int         need;
        opc  = w[31:25];
        rd   = w[24:20];
        rs1  = w[19:15];
        rs2  = w[14:10];
        need = prog.size();
        case (opc)
            ADD, SUB, AND, OR: need = later(need, later(s_last[rs1], s_last[rs2]) + 3);
            ADDI, LOAD, VBCAST: need = later(need, s_last[rs1] + 3);
            STORE: need = later(need, later(s_last[rs1], s_last[rd]) + 3);
            VADD, VSUB, VMUL: need = later(need, later(v_last[rs1], v_last[rs2]) + 4);
            VADDI: need = later(need, v_last[rs1] + 4);
            default: ;
        endcase
        while (prog.size() < need) begin
            prog.push_back(32'd0);
        end
        if (opc inside {ADD, SUB, AND, OR, ADDI, LOAD}) begin
            s_last[rd] = prog.size();
        end else if (opc inside {VADD, VSUB, VMUL, VADDI, VBCAST}) begin
            v_last[rd] = prog.size();
        end
        prog.push_back(w);
    endtask

    task automatic op_r(input logic [6:0] opc, input int rd, input int rs1, input int rs2);
        add_inst(enc(opc, rd, rs1, rs2 << 10));
    endtask

    task automatic op_i(input logic [6:0] opc, input int rd, input int rs1, input int imm);
        add_inst(enc(opc, rd, rs1, imm & 32'h7fff));
    endtask

    task automatic op_vi(input int vd, input int vs1, input int imm);
        add_inst(enc(VADDI, vd, vs1, (imm & 255) << 7));
    endtask

    // prefers a register whose writer is already far enough back
    function automatic int pick_reg(input bit vec);
        int r;
        for (int t = 0; t < 4; t++) begin
            r = rand_next() % 32;
            if (vec ? (v_last[r] + 4 <= prog.size()) : (s_last[r] + 3 <= prog.size())) begin
                return r;
            end
        end
        return r;
    endfunction

    // sequential reference, returns 1 when execution stops
    function automatic bit model_step(input logic [31:0] w);
        logic [6:0]       opc;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] st;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] res;
        logic [31:0]      vimm;
        logic [31:0]      la;
        logic [31:0]      lb;
        logic [VW-1:0]    vres;
        bit               swr;
        bit               vwr;
        opc  = w[31:25];
        rd   = w[24:20];
        rs1  = w[19:15];
        rs2  = w[14:10];
        a    = (rs1 == 0) ? '0 : m_s[rs1];
        b    = (rs2 == 0) ? '0 : m_s[rs2];
        st   = (rd == 0) ? '0 : m_s[rd];
        imm  = {{(`XLEN-15){w[14]}}, w[14:0]};
        vimm = {{24{w[14]}}, w[14:7]};
        swr  = opc inside {ADD, SUB, AND, OR, ADDI, LOAD};
        vwr  = opc inside {VADD, VSUB, VMUL, VADDI, VBCAST};
        res  = '0;
        vres = '0;
        case (opc)
            NOP: ;
            ADD: res = a + b;
            SUB: res = a - b;
            AND: res = a & b;
            OR: res = a | b;
            ADDI: res = a + imm;
            LOAD: begin
                res = a + imm;
                res = m_mem[res[5:0]];
            end
            STORE: begin
                res = a + imm;
                m_mem[res[5:0]] = st;
            end
            VADD, VSUB, VMUL, VADDI, VBCAST: ;
            default: return 1'b1;
        endcase
        if (swr) begin
            m_s[rd] = res;
            exp_s.push_back({rd, res});
            exp_s_cnt++;
        end
        if (vwr) begin
            for (int l = 0; l < `VLANES; l++) begin
                la = m_v[rs1][l*32 +: 32];
                lb = m_v[rs2][l*32 +: 32];
                case (opc)
                    VSUB: vres[l*32 +: 32] = la - lb;
                    VMUL: vres[l*32 +: 32] = la * lb;
                    VADDI: vres[l*32 +: 32] = la + vimm;
                    VBCAST: vres[l*32 +: 32] = a[31:0];
                    default: vres[l*32 +: 32] = la + lb;
                endcase
            end
            m_v[rd] = vres;
            exp_v.push_back({rd, vres});
            exp_v_cnt++;
        end
        return 1'b0;
    endfunction

    always @(negedge clk) begin
        if (rst_n && s_wb_valid) begin
            s_seen++;
            if (halted) begin
                errors++;
                $display("%s: scalar commit arrived after halted", cur_test);
            end
            if (exp_s.size() == 0) begin
                errors++;
                $display("%s: unexpected scalar commit to register %0d", cur_test, s_wb_reg);
            end else begin
                check_value("scalar commit", exp_s.pop_front(), {s_wb_reg, s_wb_data});
            end
        end
        if (rst_n && v_wb_valid) begin
            v_seen++;
            if (halted) begin
                errors++;
                $display("%s: vector commit arrived after halted", cur_test);
            end
            if (exp_v.size() == 0) begin
                errors++;
                $display("%s: unexpected vector commit to register %0d", cur_test, v_wb_reg);
            end else begin
                check_value("vector commit", exp_v.pop_front(), {v_wb_reg, v_wb_data});
            end
        end
    end

    task automatic new_program();
        prog.delete();
        for (int i = 0; i < 32; i++) begin
            s_last[i] = -10;
            v_last[i] = -10;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_mark  = errors;
        exp_s_cnt = 0;
        exp_v_cnt = 0;
        s_seen    = 0;
        v_seen    = 0;
        exp_s.delete();
        exp_v.delete();
        for (int i = 0; i < 64; i++) begin
            m_mem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            m_s[i] = '0;
            m_v[i] = '0;
        end
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        new_program();
    endtask

    task automatic run_program();
        bit stop;
        int cyc;
        stop = 1'b0;
        foreach (prog[i]) begin
            if (!stop) begin
                stop = model_step(prog[i]);
            end
        end
        foreach (prog[i]) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = i[`IMEM_AW-1:0];
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cyc   = 0;
        while (!halted && cyc < 4000) begin
            @(negedge clk);
            cyc++;
        end
        if (!halted) begin
            errors++;
            aborted = 1'b1;
            $display("%s: halted never rose within 4000 cycles", cur_test);
        end else begin
            if (exp_s.size() != 0 || exp_v.size() != 0) begin
                errors++;
                $display("%s: halted rose with %0d scalar and %0d vector commits outstanding",
                         cur_test, exp_s.size(), exp_v.size());
            end
            // a halted core must stay quiet
            repeat (10) @(negedge clk);
        end
    endtask

    task automatic end_test(input bit exp_err);
        check_value("scalar count", exp_s_cnt, s_seen);
        check_value("vector count", exp_v_cnt, v_seen);
        check_value("err", exp_err, err);
        tests++;
        $display("test %s %s, %0d error(s)", cur_test,
                 (errors == err_mark) ? "ok" : "bad", errors - err_mark);
    endtask

    task automatic test_alu();
        begin_test("alu");
        op_i(ADDI, 1, 0, -1);
        op_i(ADDI, 2, 0, 5);
        op_r(ADD, 3, 1, 2);
        op_r(SUB, 4, 0, 2);
        op_r(SUB, 5, 2, 1);
        op_r(AND, 6, 1, 2);
        op_r(OR, 7, 4, 2);
        op_i(ADDI, 8, 1, -16384);
        op_r(ADD, 9, 8, 8);
        op_i(ADDI, 0, 1, 7);
        op_r(ADD, 10, 0, 2);
        op_r(SUB, 11, 9, 3);
        prog.push_back({HALT, 25'd0});
        run_program();
        end_test(1'b0);
    endtask

    task automatic test_memory();
        begin_test("memory");
        op_i(ADDI, 1, 0, 10);
        op_i(ADDI, 2, 0, 1234);
        op_i(ADDI, 3, 0, -7);
        op_i(STORE, 2, 1, 0);
        op_i(STORE, 3, 1, 5);
        op_i(STORE, 1, 0, 63);
        op_i(LOAD, 4, 1, 0);
        op_i(LOAD, 5, 1, 5);
        op_i(LOAD, 6, 0, 63);
        // never stored
        op_i(LOAD, 7, 0, 20);
        // wraps onto address 10
        op_i(LOAD, 8, 0, 74);
        op_i(STORE, 5, 4, -1234);
        op_i(LOAD, 9, 0, 0);
        prog.push_back({HALT, 25'd0});
        run_program();
        end_test(1'b0);
    endtask

    task automatic test_vector();
        begin_test("vector");
        op_i(ADDI, 1, 0, 7);
        op_i(ADDI, 2, 0, -3);
        op_i(ADDI, 3, 0, 16383);
        op_r(VBCAST, 1, 1, 0);
        op_r(VBCAST, 2, 2, 0);
        op_r(VBCAST, 9, 3, 0);
        op_r(VADD, 3, 1, 2);
        op_r(VSUB, 4, 1, 2);
        op_r(VMUL, 5, 2, 2);
        op_r(VMUL, 6, 1, 2);
        op_vi(7, 1, -128);
        op_vi(8, 3, 127);
        op_r(VMUL, 10, 9, 9);
        op_r(VMUL, 11, 10, 10);
        prog.push_back({HALT, 25'd0});
        run_program();
        end_test(1'b0);
    endtask

    task automatic test_random();
        logic [6:0] ops [12];
        logic [6:0] opc;
        int         rd;
        ops = '{ADD, SUB, AND, OR, ADDI, LOAD, STORE, VADD, VSUB, VMUL, VADDI, VBCAST};
        begin_test("random");
        for (int n = 0; n < 200 && prog.size() < 250; n++) begin
            opc = ops[rand_next() % 12];
            rd  = rand_next() % 32;
            case (opc)
                ADDI, LOAD: op_i(opc, rd, pick_reg(1'b0), rand_next());
                STORE: op_i(opc, pick_reg(1'b0), pick_reg(1'b0), rand_next());
                VADD, VSUB, VMUL: op_r(opc, rd, pick_reg(1'b1), pick_reg(1'b1));
                VADDI: op_vi(rd, pick_reg(1'b1), rand_next());
                VBCAST: op_r(opc, rd, pick_reg(1'b0), 0);
                default: op_r(opc, rd, pick_reg(1'b0), pick_reg(1'b0));
            endcase
        end
        prog.push_back({HALT, 25'd0});
        run_program();
        end_test(1'b0);
    endtask

    task automatic test_halt();
        begin_test("halt");
        op_i(ADDI, 1, 0, 5);
        op_r(VBCAST, 3, 1, 0);
        prog.push_back({HALT, 25'd0});
        // these lie beyond HALT and never commit
        op_i(ADDI, 2, 0, 1);
        op_vi(4, 0, 9);
        run_program();
        if (!aborted) begin
            // second run keeps register state
            new_program();
            op_i(ADDI, 6, 1, 1);
            op_vi(5, 3, 2);
            prog.push_back({HALT, 25'd0});
            run_program();
        end
        end_test(1'b0);
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        op_i(ADDI, 1, 0, 3);
        op_i(ADDI, 2, 0, 4);
        op_r(ADD, 3, 1, 2);
        op_vi(2, 0, 5);
        op_i(ADDI, 5, 0, 77);
        prog.push_back(enc(7'd100, 0, 0, 0));
        op_i(ADDI, 4, 0, 9);
        op_vi(6, 0, 1);
        prog.push_back({HALT, 25'd0});
        run_program();
        end_test(1'b1);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        rng        = 32'he020a5ff;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        aborted    = 1'b0;
        test_alu();
        if (!aborted) test_memory();
        if (!aborted) test_vector();
        if (!aborted) test_random();
        if (!aborted) test_halt();
        if (!aborted) test_illegal();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/proc.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module proc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        imem_we,
    input  logic [`IMEM_AW-1:0]         imem_addr,
    input  logic [31:0]                 imem_wdata,
    output logic                        halted,
    output logic                        err,
    output logic                        s_wb_valid,
    output logic [pipe_pkg::REG_AW-1:0] s_wb_reg,
    output logic [`XLEN-1:0]            s_wb_data,
    output logic                        v_wb_valid,
    output logic [pipe_pkg::REG_AW-1:0] v_wb_reg,
    output logic [`VLANES*`VLANE_W-1:0] v_wb_data
);
    import pipe_pkg::*;

    localparam int SDEPTH = 3;
    localparam int VDEPTH = `VSTAGES + 1;

    logic [31:0]                 inst_f;
    logic [31:0]                 inst_d;
    logic                        inst_valid_f;
    logic                        inst_valid_d;
    logic [`XLEN-1:0]            sdata1_d, sdata2_d, sdata_st_d, imm_d;
    logic [`XLEN-1:0]            sdata1_e, sdata2_e, sdata_st_e, imm_e;
    logic [`XLEN-1:0]            sdata_st_m;
    logic [`XLEN-1:0]            addr_m;
    logic [`VLANES*`VLANE_W-1:0] vdata1_d, vdata2_d, vdata1_e, vdata2_e;
    logic [`VLANE_W-1:0]         vimm_d, vimm_e;

    // entry 0 comes from decode, the last entry is writeback
    logic [SDEPTH:0] s_valid_p;
    s_ctrl_t         s_ctrl_p [SDEPTH+1];
    logic [VDEPTH:0] v_valid_p;
    v_ctrl_t         v_ctrl_p [VDEPTH+1];

    fetch i_fetch (
        .clk, .rst_n, .start, .stop(err),
        .imem_we, .imem_addr, .imem_wdata,
        .inst(inst_f), .inst_valid(inst_valid_f), .halted
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_d       <= '0;
            inst_valid_d <= 1'b0;
        end else begin
            inst_d       <= inst_f;
            inst_valid_d <= inst_valid_f;
        end
    end

    decode i_decode (
        .clk, .rst_n, .inst(inst_d), .inst_valid(inst_valid_d),
        .s_we(s_wb_valid), .s_waddr(s_wb_reg), .s_wdata(s_wb_data),
        .v_we(v_wb_valid), .v_waddr(v_wb_reg), .v_wdata(v_wb_data),
        .sdata1(sdata1_d), .sdata2(sdata2_d), .sdata_st(sdata_st_d), .imm(imm_d),
        .vdata1(vdata1_d), .vdata2(vdata2_d), .vimm(vimm_d),
        .s_valid(s_valid_p[0]), .s_ctrl(s_ctrl_p[0]),
        .v_valid(v_valid_p[0]), .v_ctrl(v_ctrl_p[0]),
        .err
    );

    always_ff @(posedge clk) begin
        sdata1_e   <= sdata1_d;
        sdata2_e   <= sdata2_d;
        sdata_st_e <= sdata_st_d;
        imm_e      <= imm_d;
        vdata1_e   <= vdata1_d;
        vdata2_e   <= vdata2_d;
        vimm_e     <= vimm_d;
        sdata_st_m <= sdata_st_e;
    end

    // err drops everything younger than the illegal instruction
    for (genvar i = 0; i < SDEPTH; i++) begin : g_s_ctrl
        control_pipeline #(.payload_t(s_ctrl_t)) i_stage (
            .clk, .rst_n, .flush(i == 0 ? err : 1'b0),
            .valid_d(s_valid_p[i]), .ctrl_d(s_ctrl_p[i]),
            .valid_q(s_valid_p[i+1]), .ctrl_q(s_ctrl_p[i+1])
        );
    end

    for (genvar i = 0; i < VDEPTH; i++) begin : g_v_ctrl
        control_pipeline #(.payload_t(v_ctrl_t)) i_stage (
            .clk, .rst_n, .flush(i == 0 ? err : 1'b0),
            .valid_d(v_valid_p[i]), .ctrl_d(v_ctrl_p[i]),
            .valid_q(v_valid_p[i+1]), .ctrl_q(v_ctrl_p[i+1])
        );
    end

    scalar_execute i_scalar_execute (
        .clk, .rst_n, .data1(sdata1_e), .data2(sdata2_e), .imm(imm_e),
        .ctrl(s_ctrl_p[1]), .result(addr_m)
    );

    scalar_memory i_scalar_memory (
        .clk, .rst_n, .valid(s_valid_p[2]), .ctrl(s_ctrl_p[2]),
        .addr(addr_m), .store_data(sdata_st_m), .wb_data(s_wb_data)
    );

    vector_execute i_vector_execute (
        .clk, .rst_n, .vdata1(vdata1_e), .vdata2(vdata2_e), .sdata1(sdata1_e),
        .vimm(vimm_e), .ctrl(v_ctrl_p[1]), .vdata_out(v_wb_data)
    );

    // stores leave no trace at writeback
    assign s_wb_valid = s_valid_p[SDEPTH] && s_ctrl_p[SDEPTH].reg_we;
    assign s_wb_reg   = s_ctrl_p[SDEPTH].wreg;
    assign v_wb_valid = v_valid_p[VDEPTH] && v_ctrl_p[VDEPTH].vwe;
    assign v_wb_reg   = v_ctrl_p[VDEPTH].wreg;

    quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !(s_wb_valid || v_wb_valid))
        else $error("commit seen after halted");

endmodule

`default_nettype wire

// ==== hdl/vector_execute.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module vector_execute (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`VLANES*`VLANE_W-1:0] vdata1,
    input  logic [`VLANES*`VLANE_W-1:0] vdata2,
    input  logic [`XLEN-1:0]            sdata1,
    input  logic [`VLANE_W-1:0]         vimm,
    input  pipe_pkg::v_ctrl_t           ctrl,
    output logic [`VLANES*`VLANE_W-1:0] vdata_out
);
    import pipe_pkg::*;

    localparam int W = `VLANE_W;

    lane_op_e             op_q;
    logic [`VLANES*W-1:0] a_q;
    logic [`VLANES*W-1:0] b_q;
    logic [`VLANES*W-1:0] r_q;

    function automatic logic [W-1:0] lane_alu(input lane_op_e op, input logic [W-1:0] a,
                                              input logic [W-1:0] b);
        case (op)
            LANE_SUB:   return a - b;
            // only the low half of the product is kept
            LANE_MUL:   return a * b;
            LANE_BCAST: return a;
            default:    return a + b;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= LANE_ADD;
        end else begin
            op_q <= ctrl.lane_op;
        end
    end

    // stage 1 selects operands, stage 2 computes, stage 3 holds for writeback
    always_ff @(posedge clk) begin
        for (int l = 0; l < `VLANES; l++) begin
            a_q[l*W +: W] <= (ctrl.lane_op == LANE_BCAST) ? sdata1[W-1:0]
                                                          : vdata1[l*W +: W];
            b_q[l*W +: W] <= (ctrl.lane_op == LANE_ADDI) ? vimm : vdata2[l*W +: W];
            r_q[l*W +: W] <= lane_alu(op_q, a_q[l*W +: W], b_q[l*W +: W]);
        end
        vdata_out <= r_q;
    end

endmodule

`default_nettype wire

// ==== hdl/scalar_memory.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module scalar_memory (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  pipe_pkg::s_ctrl_t ctrl,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  store_data,
    output logic [`XLEN-1:0]  wb_data
);

    logic [`XLEN-1:0]    mem [2**`DMEM_AW];
    logic [`DMEM_AW-1:0] idx;

    // upper address bits are ignored
    assign idx = addr[`DMEM_AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`DMEM_AW; i++) begin
                mem[i] <= '0;
            end
            wb_data <= '0;
        end else begin
            if (valid && ctrl.mem_write) begin
                mem[idx] <= store_data;
            end
            // ALU results pass through in place of load data
            wb_data <= ctrl.mem_read ? mem[idx] : addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scalar_execute.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module scalar_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`XLEN-1:0]  data1,
    input  logic [`XLEN-1:0]  data2,
    input  logic [`XLEN-1:0]  imm,
    input  pipe_pkg::s_ctrl_t ctrl,
    output logic [`XLEN-1:0]  result
);
    import pipe_pkg::*;

    alu_op_e          op;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;

    // loads and stores always form base plus offset
    assign op   = (ctrl.mem_read || ctrl.mem_write) ? ALU_ADD : ctrl.alu_op;
    assign op_b = ctrl.use_imm ? imm : data2;

    always_comb begin
        case (op)
            ALU_SUB: alu_out = data1 - op_b;
            ALU_AND: alu_out = data1 & op_b;
            ALU_OR:  alu_out = data1 | op_b;
            default: alu_out = data1 + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   inst,
    input  logic                          inst_valid,
    input  logic                          s_we,
    input  logic [pipe_pkg::REG_AW-1:0]   s_waddr,
    input  logic [`XLEN-1:0]              s_wdata,
    input  logic                          v_we,
    input  logic [pipe_pkg::REG_AW-1:0]   v_waddr,
    input  logic [`VLANES*`VLANE_W-1:0]   v_wdata,
    output logic [`XLEN-1:0]              sdata1,
    output logic [`XLEN-1:0]              sdata2,
    output logic [`XLEN-1:0]              sdata_st,
    output logic [`XLEN-1:0]              imm,
    output logic [`VLANES*`VLANE_W-1:0]   vdata1,
    output logic [`VLANES*`VLANE_W-1:0]   vdata2,
    output logic [`VLANE_W-1:0]           vimm,
    output logic                          s_valid,
    output pipe_pkg::s_ctrl_t             s_ctrl,
    output logic                          v_valid,
    output pipe_pkg::v_ctrl_t             v_ctrl,
    output logic                          err
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0]            sregs [`NREGS];
    logic [`VLANES*`VLANE_W-1:0] vregs [`NREGS];
    logic [6:0]                  opc;
    logic [REG_AW-1:0]           rd;
    logic [REG_AW-1:0]           rs1;
    logic [REG_AW-1:0]           rs2;
    logic                        is_scalar;
    logic                        is_vector;
    logic                        illegal;

    // reads see a write landing on the same edge
    function automatic logic [`XLEN-1:0] sread(input logic [REG_AW-1:0] a);
        if (a == '0) begin
            return '0;
        end
        return (s_we && s_waddr == a) ? s_wdata : sregs[a];
    endfunction

    function automatic logic [`VLANES*`VLANE_W-1:0] vread(input logic [REG_AW-1:0] a);
        return (v_we && v_waddr == a) ? v_wdata : vregs[a];
    endfunction

    assign opc  = inst[OPC_HI:OPC_LO];
    assign rd   = inst[RD_HI:RD_LO];
    assign rs1  = inst[RS1_HI:RS1_LO];
    assign rs2  = inst[RS2_HI:RS2_LO];
    assign imm  = {{(`XLEN-15){inst[IMM_HI]}}, inst[IMM_HI:IMM_LO]};
    assign vimm = {{(`VLANE_W-8){inst[VIMM_HI]}}, inst[VIMM_HI:VIMM_LO]};

    always_comb begin
        sdata1   = sread(rs1);
        sdata2   = sread(rs2);
        sdata_st = sread(rd);
        vdata1   = vread(rs1);
        vdata2   = vread(rs2);
    end

    assign is_scalar = opc inside {ADD, SUB, AND, OR, ADDI, LOAD, STORE};
    assign is_vector = opc inside {VADD, VSUB, VMUL, VADDI, VBCAST};
    assign illegal   = inst_valid && !(is_scalar || is_vector || opc inside {NOP, HALT});
    assign s_valid   = inst_valid && is_scalar;
    assign v_valid   = inst_valid && is_vector;

    always_comb begin
        s_ctrl.alu_op    = ALU_ADD;
        s_ctrl.use_imm   = opc inside {ADDI, LOAD, STORE};
        s_ctrl.reg_we    = is_scalar && opc != STORE;
        s_ctrl.mem_read  = opc == LOAD;
        s_ctrl.mem_write = opc == STORE;
        s_ctrl.wreg      = rd;
        v_ctrl.lane_op   = LANE_ADD;
        v_ctrl.vwe       = is_vector;
        v_ctrl.wreg      = rd;
        case (opc)
            SUB:     s_ctrl.alu_op = ALU_SUB;
            AND:     s_ctrl.alu_op = ALU_AND;
            OR:      s_ctrl.alu_op = ALU_OR;
            VSUB:    v_ctrl.lane_op = LANE_SUB;
            VMUL:    v_ctrl.lane_op = LANE_MUL;
            VADDI:   v_ctrl.lane_op = LANE_ADDI;
            VBCAST:  v_ctrl.lane_op = LANE_BCAST;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                sregs[i] <= '0;
                vregs[i] <= '0;
            end
            err <= 1'b0;
        end else begin
            if (s_we) begin
                sregs[s_waddr] <= s_wdata;
            end
            if (v_we) begin
                vregs[v_waddr] <= v_wdata;
            end
            // sticky until the next reset
            if (illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "proc_defs.svh"

module fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                stop,
    input  logic                imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  logic [31:0]         imem_wdata,
    output logic [31:0]         inst,
    output logic                inst_valid,
    output logic                halted
);
    import isa_pkg::*;

    localparam int CW = $clog2(`DRAIN + 1);

    logic [31:0]         imem [2**`IMEM_AW];
    logic [31:0]         word;
    logic [`IMEM_AW-1:0] pc;
    logic                running;
    logic                draining;
    logic                freeze;
    logic [CW-1:0]       drain_cnt;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign word       = imem[pc];
    assign freeze     = running && (stop || word[OPC_HI:OPC_LO] == HALT);
    // HALT itself goes down the pipe as a NOP
    assign inst       = freeze ? {NOP, 25'd0} : word;
    assign inst_valid = running;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            running   <= 1'b0;
            draining  <= 1'b0;
            drain_cnt <= '0;
            halted    <= 1'b0;
        end else if (start) begin
            pc       <= '0;
            running  <= 1'b1;
            draining <= 1'b0;
            halted   <= 1'b0;
        end else if (freeze) begin
            running   <= 1'b0;
            draining  <= 1'b1;
            drain_cnt <= CW'(`DRAIN - 1);
        end else if (running) begin
            pc <= pc + 1'b1;
        end else if (draining) begin
            drain_cnt <= drain_cnt - 1'b1;
            // older instructions have all committed by now
            if (drain_cnt == CW'(1)) begin
                draining <= 1'b0;
                halted   <= 1'b1;
            end
        end
    end

    imem_idle: assert property (@(posedge clk) disable iff (!rst_n) imem_we |-> !running)
        else $error("instruction memory written while running");

endmodule

`default_nettype wire

// ==== hdl/control_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ns

module control_pipeline #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     valid_d,
    input  payload_t ctrl_d,
    output logic     valid_q,
    output payload_t ctrl_q
);

    // a flushed slot keeps its payload but never reaches writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_d && !flush;
        end
    end

    always_ff @(posedge clk) begin
        ctrl_q <= ctrl_d;
    end

    valid_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(valid_q))
        else $error("control valid went unknown");

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

`include "proc_defs.svh"

package pipe_pkg;

    localparam int REG_AW = $clog2(`NREGS);

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    typedef enum logic [2:0] {
        LANE_ADD,
        LANE_SUB,
        LANE_MUL,
        LANE_ADDI,
        LANE_BCAST
    } lane_op_e;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              use_imm;
        logic              reg_we;
        logic              mem_read;
        logic              mem_write;
        logic [REG_AW-1:0] wreg;
    } s_ctrl_t;

    typedef struct packed {
        lane_op_e          lane_op;
        logic              vwe;
        logic [REG_AW-1:0] wreg;
    } v_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        NOP    = 7'd0,
        ADD    = 7'd1,
        SUB    = 7'd2,
        AND    = 7'd3,
        OR     = 7'd4,
        ADDI   = 7'd5,
        LOAD   = 7'd6,
        STORE  = 7'd7,
        VADD   = 7'd8,
        VSUB   = 7'd9,
        VMUL   = 7'd10,
        VADDI  = 7'd11,
        VBCAST = 7'd12,
        HALT   = 7'd13
    } opcode_e;

    // instruction word fields
    localparam int OPC_HI  = 31;
    localparam int OPC_LO  = 25;
    localparam int RD_HI   = 24;
    localparam int RD_LO   = 20;
    localparam int RS1_HI  = 19;
    localparam int RS1_LO  = 15;
    localparam int RS2_HI  = 14;
    localparam int RS2_LO  = 10;
    // scalar immediate overlaps rs2, store data comes from rd
    localparam int IMM_HI  = 14;
    localparam int IMM_LO  = 0;
    localparam int VIMM_HI = 14;
    localparam int VIMM_LO = 7;

endpackage

`default_nettype wire

// ==== hdl/proc_defs.svh ====
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// scalar and vector datapath widths
`define XLEN    36
`define VLANE_W 32
`define VLANES  4
`define NREGS   32

// memory address widths
`define IMEM_AW 8
`define DMEM_AW 6

// vector unit depth
`define VSTAGES 3
// cycles from a fetched HALT until halted is raised
`define DRAIN   7

`endif
